// ==== hw/lp20_defs.svh ====
// LP20 register offsets and CSRA field positions

`ifndef LP20_DEFS_SVH
`define LP20_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Register word offsets
////////////////////////////////////////////////////////////////////////////

`define LP_OFF_CSRA  2'd0
`define LP_OFF_BAR   2'd1
`define LP_OFF_BCTR  2'd2
`define LP_OFF_PCTR  2'd3

////////////////////////////////////////////////////////////////////////////
// CSRA bit positions
////////////////////////////////////////////////////////////////////////////

// High byte
`define LP_CSRA_ERR       15
`define LP_CSRA_PCZ       14
`define LP_CSRA_UNDC      13
`define LP_CSRA_VFURDY    12
`define LP_CSRA_ONLINE    11
`define LP_CSRA_DHLD      10
`define LP_CSRA_ECLR      9
`define LP_CSRA_INIT      8

// Low byte
`define LP_CSRA_DONE      7
`define LP_CSRA_IE        6
`define LP_CSRA_BARHI_HI  5
`define LP_CSRA_BARHI_LO  4
`define LP_CSRA_MODE_HI   3
`define LP_CSRA_MODE_LO   2
`define LP_CSRA_PAR       1
`define LP_CSRA_GO        0

`endif

// ==== hw/lpPkg.sv ====
// LP20 register slice types shared by the RTL and the testbench

package lpPkg;

   //////////////////////////////////////////////////////////////////////////
   // Bus and register widths
   //////////////////////////////////////////////////////////////////////////

   // Device bus data word
   typedef logic [35:0] lpData_t;

   // Register image as read by the host
   typedef logic [15:0] lpReg_t;

   // DMA bus address, BAR plus the two CSRA extension bits
   typedef logic [17:0] lpBusAddr_t;

   // Byte or page count
   typedef logic [11:0] lpCount_t;

   // Register word offset on the device bus
   typedef logic [1:0] lpOffset_t;

endpackage

// ==== hw/lpRegDecode.sv ====
// LP20 register decode, write strobes per register and host read mux

`timescale 1ns/1ps

`include "lp20_defs.svh"

module lpRegDecode import lpPkg::*; (
   input  lpOffset_t devAddr,
   input  logic      devWrite,
   input  logic      devLoByte,
   input  logic      devHiByte,
   input  lpReg_t    regCsra,
   input  lpReg_t    regBar,
   input  lpCount_t  regBctr,
   input  lpCount_t  regPctr,
   output logic      csraWrite,
   output logic      barWrite,
   output logic      bctrWrite,
   output logic      pctrWrite,
   output lpReg_t    regOut
);

   // A write with no byte lane selected touches nothing
   logic laneWrite;

   assign laneWrite = devWrite & (devLoByte | devHiByte);

   // One strobe per register offset
   assign csraWrite = laneWrite & (devAddr == `LP_OFF_CSRA);
   assign barWrite  = laneWrite & (devAddr == `LP_OFF_BAR);
   assign bctrWrite = laneWrite & (devAddr == `LP_OFF_BCTR);
   assign pctrWrite = laneWrite & (devAddr == `LP_OFF_PCTR);

   // Read mux, counters zero-extended to 16 bits
   always_comb
   begin
      case (devAddr)
         `LP_OFF_CSRA: regOut = regCsra;
         `LP_OFF_BAR:  regOut = regBar;
         `LP_OFF_BCTR: regOut = {4'b0000, regBctr};
         default:      regOut = {4'b0000, regPctr};
      endcase
   end

endmodule

// ==== hw/lpCsra.sv ====
// LP20 control and status register A with sticky status and interrupt set term

`timescale 1ns/1ps

`include "lp20_defs.svh"

module lpCsra import lpPkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  logic       devReset,
   input  logic       devLoByte,
   input  logic       devHiByte,
   input  logic       bctrWrite,
   input  logic       pctrWrite,
   input  logic       csraWrite,
   input  lpData_t    devData,
   input  logic       online,
   input  logic       lpe,
   input  logic       vfuRdy,
   input  logic       cmdGo,
   input  logic       setUndc,
   input  logic       setMpe,
   input  logic       setDhld,
   input  logic       clrDhld,
   input  logic       setPcz,
   input  logic       setDone,
   input  logic [1:0] busAddrHi,
   output logic       init,
   output lpReg_t     regCsra,
   output logic       setIrq
);

   logic eclr;
   logic lastOnline;
   logic lastVfuRdy;
   logic lastLpe;
   logic setErr;
   logic err;
   logic pcz;
   logic undc;
   logic dhld;
   logic done;
   logic ie;
   logic [1:0] mode;
   logic par;

   logic loWrite;
   logic hiWrite;

   assign loWrite = csraWrite & devLoByte;
   assign hiWrite = csraWrite & devHiByte;

   ////////////////////////////////////////////////////////////////////////////
   // Write-only pulses
   ////////////////////////////////////////////////////////////////////////////

   // Bus reset or INIT written high
   assign init = devReset | (hiWrite & devData[`LP_CSRA_INIT]);

   // Error clear, also implied by init
   assign eclr = init | (hiWrite & devData[`LP_CSRA_ECLR]);

   ////////////////////////////////////////////////////////////////////////////
   // Printer level edges
   ////////////////////////////////////////////////////////////////////////////

   // One registered copy of each level
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         lastOnline <= 1'b0;
         lastVfuRdy <= 1'b0;
         lastLpe    <= 1'b0;
      end
      else
      begin
         lastOnline <= online;
         lastVfuRdy <= vfuRdy;
         lastLpe    <= lpe;
      end
   end

   // Parity fault, online drop, VFU drop, printer parity rise
   assign setErr = setMpe | (~online & lastOnline) | (~vfuRdy & lastVfuRdy)
                 | (lpe & ~lastLpe);

   ////////////////////////////////////////////////////////////////////////////
   // Sticky status bits
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         err  <= 1'b0;
         pcz  <= 1'b0;
         undc <= 1'b0;
         dhld <= 1'b0;
         done <= 1'b0;
      end
      else
      begin
         // ERR holds until an error clear
         if (eclr)
            err <= 1'b0;
         else if (setErr)
            err <= 1'b1;
         // PCZ, clear wins over set
         if (init | pctrWrite)
            pcz <= 1'b0;
         else if (setPcz)
            pcz <= 1'b1;
         // UNDC dropped by a new go command
         if (cmdGo)
            undc <= 1'b0;
         else if (setUndc)
            undc <= 1'b1;
         // DHLD, then host may write it directly
         if (init | clrDhld)
            dhld <= 1'b0;
         else if (setDhld)
            dhld <= 1'b1;
         else if (hiWrite)
            dhld <= devData[`LP_CSRA_DHLD];
         // DONE set by init as well
         if (bctrWrite)
            done <= 1'b0;
         else if (init | setDone)
            done <= 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Host control bits, low byte
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst | init)
      begin
         ie   <= 1'b0;
         mode <= 2'b00;
         par  <= 1'b0;
      end
      else if (loWrite)
      begin
         ie   <= devData[`LP_CSRA_IE];
         mode <= devData[`LP_CSRA_MODE_HI:`LP_CSRA_MODE_LO];
         par  <= devData[`LP_CSRA_PAR];
      end
   end

   // Read image, GO follows the live go command
   assign regCsra = {err, pcz, undc, vfuRdy, online, dhld, eclr, init,
                     done, ie, busAddrHi, mode, par, cmdGo};

   // Any error, PCZ, UNDC or DONE set, or either level changing
   assign setIrq = setErr | setPcz | setUndc | setDone
                 | (vfuRdy != lastVfuRdy) | (online != lastOnline);

endmodule

// ==== hw/lpBar.sv ====
// LP20 bus address register, host loaded and stepped by DMA

`timescale 1ns/1ps

`include "lp20_defs.svh"

module lpBar import lpPkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  logic       init,
   input  logic       barWrite,
   input  logic       csraWrite,
   input  logic       devLoByte,
   input  logic       devHiByte,
   input  lpData_t    devData,
   input  logic       dmaByte,
   output lpBusAddr_t busAddr
);

   // Writes win over the DMA step
   always_ff @(posedge clk)
   begin
      if (rst | init)
         busAddr <= '0;
      else if (barWrite)
      begin
         if (devLoByte)
            busAddr[7:0] <= devData[7:0];
         if (devHiByte)
            busAddr[15:8] <= devData[15:8];
      end
      // Extension bits live in the CSRA low byte
      else if (csraWrite & devLoByte)
         busAddr[17:16] <= devData[`LP_CSRA_BARHI_HI:`LP_CSRA_BARHI_LO];
      else if (dmaByte)
         busAddr <= busAddr + 18'd1;
   end

endmodule

// ==== hw/lpCounters.sv ====
// LP20 byte and page counters with done and page-count-zero events

`timescale 1ns/1ps

module lpCounters import lpPkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  logic     init,
   input  logic     bctrWrite,
   input  logic     pctrWrite,
   input  logic     devLoByte,
   input  logic     devHiByte,
   input  lpData_t  devData,
   input  logic     dmaByte,
   input  logic     formFeed,
   output lpCount_t regBctr,
   output lpCount_t regPctr,
   output logic     setDone,
   output logic     setPcz
);

   logic bctrStep;
   logic pctrStep;

   // Counting only when neither init nor a host write takes the cycle
   assign bctrStep = dmaByte & ~init & ~bctrWrite;
   assign pctrStep = formFeed & ~init & ~pctrWrite & (regPctr != 12'd0);

   // Wrap of the byte count ends the transfer
   assign setDone = bctrStep & (regBctr == 12'hFFF);

   // Last page printed
   assign setPcz = pctrStep & (regPctr == 12'd1);

   ////////////////////////////////////////////////////////////////////////////
   // Byte counter, counts up
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst | init)
         regBctr <= '0;
      else if (bctrWrite)
      begin
         if (devLoByte)
            regBctr[7:0] <= devData[7:0];
         if (devHiByte)
            regBctr[11:8] <= devData[11:8];
      end
      else if (bctrStep)
         regBctr <= regBctr + 12'd1;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Page counter, counts down and stops at zero
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst | init)
         regPctr <= '0;
      else if (pctrWrite)
      begin
         if (devLoByte)
            regPctr[7:0] <= devData[7:0];
         if (devHiByte)
            regPctr[11:8] <= devData[11:8];
      end
      else if (pctrStep)
         regPctr <= regPctr - 12'd1;
   end

endmodule

// ==== hw/lpIntr.sv ====
// LP20 interrupt pending latch with enable and host acknowledge

`timescale 1ns/1ps

module lpIntr (
   input  logic clk,
   input  logic rst,
   input  logic init,
   input  logic setIrq,
   input  logic ie,
   input  logic irqAck,
   output logic irq
);

   logic pending;

   // Set beats acknowledge in the same cycle
   always_ff @(posedge clk)
   begin
      if (rst)
         pending <= 1'b0;
      else if (setIrq)
         pending <= 1'b1;
      else if (irqAck | init)
         pending <= 1'b0;
   end

   // Request only while enabled
   assign irq = pending & ie;

endmodule

// ==== hw/lpRegs.sv ====
// LP20 register slice top level, decode, CSRA, BAR, counters and interrupt

`timescale 1ns/1ps

`include "lp20_defs.svh"

module lpRegs import lpPkg::*; (
   input  logic       clk,
   input  logic       rst,
   // Host device bus
   input  lpOffset_t  devAddr,
   input  logic       devWrite,
   input  logic       devLoByte,
   input  logic       devHiByte,
   input  lpData_t    devData,
   input  logic       devReset,
   input  logic       irqAck,
   // DMA side strobes
   input  logic       dmaByte,
   input  logic       formFeed,
   input  logic       cmdGo,
   input  logic       setUndc,
   input  logic       setMpe,
   input  logic       setDhld,
   input  logic       clrDhld,
   // Printer levels
   input  logic       online,
   input  logic       vfuRdy,
   input  logic       lpe,
   output lpReg_t     regOut,
   output lpBusAddr_t busAddr,
   output logic       irq
);

   logic     csraWrite;
   logic     barWrite;
   logic     bctrWrite;
   logic     pctrWrite;
   logic     init;
   logic     setIrq;
   logic     setDone;
   logic     setPcz;
   lpReg_t   regCsra;
   lpCount_t regBctr;
   lpCount_t regPctr;

   ////////////////////////////////////////////////////////////////////////////
   // Decode and read mux
   ////////////////////////////////////////////////////////////////////////////

   lpRegDecode lpRegDecode_i (
      .devAddr   (devAddr),
      .devWrite  (devWrite),
      .devLoByte (devLoByte),
      .devHiByte (devHiByte),
      .regCsra   (regCsra),
      .regBar    (busAddr[15:0]),
      .regBctr   (regBctr),
      .regPctr   (regPctr),
      .csraWrite (csraWrite),
      .barWrite  (barWrite),
      .bctrWrite (bctrWrite),
      .pctrWrite (pctrWrite),
      .regOut    (regOut)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Registers
   ////////////////////////////////////////////////////////////////////////////

   lpCsra lpCsra_i (
      .clk       (clk),
      .rst       (rst),
      .devReset  (devReset),
      .devLoByte (devLoByte),
      .devHiByte (devHiByte),
      .bctrWrite (bctrWrite),
      .pctrWrite (pctrWrite),
      .csraWrite (csraWrite),
      .devData   (devData),
      .online    (online),
      .lpe       (lpe),
      .vfuRdy    (vfuRdy),
      .cmdGo     (cmdGo),
      .setUndc   (setUndc),
      .setMpe    (setMpe),
      .setDhld   (setDhld),
      .clrDhld   (clrDhld),
      .setPcz    (setPcz),
      .setDone   (setDone),
      .busAddrHi (busAddr[17:16]),
      .init      (init),
      .regCsra   (regCsra),
      .setIrq    (setIrq)
   );

   lpBar lpBar_i (
      .clk       (clk),
      .rst       (rst),
      .init      (init),
      .barWrite  (barWrite),
      .csraWrite (csraWrite),
      .devLoByte (devLoByte),
      .devHiByte (devHiByte),
      .devData   (devData),
      .dmaByte   (dmaByte),
      .busAddr   (busAddr)
   );

   lpCounters lpCounters_i (
      .clk       (clk),
      .rst       (rst),
      .init      (init),
      .bctrWrite (bctrWrite),
      .pctrWrite (pctrWrite),
      .devLoByte (devLoByte),
      .devHiByte (devHiByte),
      .devData   (devData),
      .dmaByte   (dmaByte),
      .formFeed  (formFeed),
      .regBctr   (regBctr),
      .regPctr   (regPctr),
      .setDone   (setDone),
      .setPcz    (setPcz)
   );

   // Interrupt, enable taken from the CSRA image
   lpIntr lpIntr_i (
      .clk    (clk),
      .rst    (rst),
      .init   (init),
      .setIrq (setIrq),
      .ie     (regCsra[`LP_CSRA_IE]),
      .irqAck (irqAck),
      .irq    (irq)
   );

endmodule

// ==== verification/lpRegsTb.sv ====
// LP20 register slice testbench that replays the operation table and checks read data and irq

`timescale 1ns/1ps

`include "lp20_defs.svh"

module lpRegsTb import lpPkg::*; #(
   parameter logic [31:0] rngSeed = 32'h91aa82cb
);

   localparam int fieldsPerOp = 7;
   localparam int maxOps      = 64;
   localparam int burstLen    = 16;

   logic       clk;
   logic       rst;
   lpOffset_t  devAddr;
   logic       devWrite;
   logic       devLoByte;
   logic       devHiByte;
   lpData_t    devData;
   logic       devReset;
   logic       irqAck;
   logic       dmaByte;
   logic       formFeed;
   logic       cmdGo;
   logic       setUndc;
   logic       setMpe;
   logic       setDhld;
   logic       clrDhld;
   logic       online;
   logic       vfuRdy;
   logic       lpe;
   lpReg_t     regOut;
   lpBusAddr_t busAddr;
   logic       irq;

   // Seven words per operation as laid out in the data file header
   logic [35:0] testMem [0:fieldsPerOp*maxOps-1];
   int          numOps;
   int          limitCycles;
   logic [31:0] randBits;

   lpRegs lpRegs_i (
      .clk       (clk),
      .rst       (rst),
      .devAddr   (devAddr),
      .devWrite  (devWrite),
      .devLoByte (devLoByte),
      .devHiByte (devHiByte),
      .devData   (devData),
      .devReset  (devReset),
      .irqAck    (irqAck),
      .dmaByte   (dmaByte),
      .formFeed  (formFeed),
      .cmdGo     (cmdGo),
      .setUndc   (setUndc),
      .setMpe    (setMpe),
      .setDhld   (setDhld),
      .clrDhld   (clrDhld),
      .online    (online),
      .vfuRdy    (vfuRdy),
      .lpe       (lpe),
      .regOut    (regOut),
      .busAddr   (busAddr),
      .irq       (irq)
   );

   // 4 ns clock
   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////////////////////////////////////////

   // All one-cycle strobes low while printer levels stay
   task automatic dropStrobes();
      devWrite  = 1'b0;
      devLoByte = 1'b0;
      devHiByte = 1'b0;
      devData   = '0;
      devReset  = 1'b0;
      irqAck    = 1'b0;
      dmaByte   = 1'b0;
      formFeed  = 1'b0;
      cmdGo     = 1'b0;
      setUndc   = 1'b0;
      setMpe    = 1'b0;
      setDhld   = 1'b0;
      clrDhld   = 1'b0;
   endtask

   // Pulses in the low bits and levels in bits 11:9
   task automatic applyEvents(input logic [11:0] mask);
      dmaByte  = mask[0];
      formFeed = mask[1];
      cmdGo    = mask[2];
      setUndc  = mask[3];
      setMpe   = mask[4];
      setDhld  = mask[5];
      clrDhld  = mask[6];
      irqAck   = mask[7];
      devReset = mask[8];
      online   = mask[9];
      vfuRdy   = mask[10];
      lpe      = mask[11];
   endtask

   task automatic busWrite(input lpOffset_t offset, input logic [1:0] lanes,
                           input lpData_t data);
      @(negedge clk);
      devAddr   = offset;
      devWrite  = 1'b1;
      devLoByte = lanes[0];
      devHiByte = lanes[1];
      devData   = data;
      @(negedge clk);
      dropStrobes();
   endtask

   task automatic compareValue(input string sigName, input logic [17:0] expected,
                               input logic [17:0] actual);
      assert (actual === expected)
      else
      begin
         $display("MISMATCH at %0t: %s expected %h, actual %h",
                  $time, sigName, expected, actual);
         $display("Finished with errors");
         $fatal(1);
      end
   endtask

   function automatic logic isOpCode(input logic [35:0] word);
      return (word == 36'd1) || (word == 36'd2) || (word == 36'd3);
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Drive one table row and check it a cycle later
   ////////////////////////////////////////////////////////////////////////////

   task automatic runOp(input int idx);
      int          base;
      logic [35:0] opCode;
      lpReg_t      expReg;
      logic        expIrq;
      base   = fieldsPerOp * idx;
      opCode = testMem[base];
      expReg = testMem[base + 5][15:0];
      expIrq = testMem[base + 6][0];
      @(negedge clk);
      devAddr = testMem[base + 1][1:0];
      // 1 write, 2 event, 3 read only
      if (opCode == 36'd1)
      begin
         devWrite  = 1'b1;
         devLoByte = testMem[base + 2][0];
         devHiByte = testMem[base + 2][1];
         devData   = testMem[base + 3];
      end
      else if (opCode == 36'd2)
         applyEvents(testMem[base + 4][11:0]);
      @(negedge clk);
      dropStrobes();
      #1;
      compareValue("regOut", {2'b00, expReg}, {2'b00, regOut});
      compareValue("irq", {17'd0, expIrq}, {17'd0, irq});
   endtask

   // Random DMA steps across the 16-bit boundary into the CSRA extension bits
   task automatic checkBarBurst();
      int         pulseCount;
      lpBusAddr_t expAddr;
      pulseCount = 0;
      busWrite(`LP_OFF_BAR, 2'b11, 36'h00000FFF0);
      busWrite(`LP_OFF_CSRA, 2'b01, 36'd1 << `LP_CSRA_BARHI_LO);
      #1;
      compareValue("busAddr", 18'h1FFF0, busAddr);
      for (int i = 0; i < burstLen; i++)
      begin
         @(negedge clk);
         randBits = $urandom;
         dmaByte  = randBits[0];
         if (randBits[0])
            pulseCount++;
      end
      @(negedge clk);
      dmaByte = 1'b0;
      #1;
      expAddr = 18'h1FFF0 + 18'(pulseCount);
      compareValue("busAddr", expAddr, busAddr);
   endtask

   // Byte count wrap with IE set raises irq one cycle after the last DMA byte
   task automatic wrapRaisesIrq();
      busWrite(`LP_OFF_CSRA, 2'b01, 36'd1 << `LP_CSRA_IE);
      busWrite(`LP_OFF_BCTR, 2'b11, 36'h000000FFF);
      #1;
      compareValue("irq", 18'd0, {17'd0, irq});
      @(negedge clk);
      dmaByte = 1'b1;
      @(negedge clk);
      dmaByte = 1'b0;
      #1;
      compareValue("irq", 18'd1, {17'd0, irq});
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence and watchdog
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      rst         = 1'b1;
      devAddr     = '0;
      online      = 1'b0;
      vfuRdy      = 1'b0;
      lpe         = 1'b0;
      limitCycles = 0;
      dropStrobes();
      randBits = $urandom(rngSeed);
      $readmemh("verification/lpRegs_testdata.txt", testMem);
      numOps = 0;
      while (numOps < maxOps && isOpCode(testMem[fieldsPerOp * numOps]))
         numOps++;
      if (numOps == 0)
      begin
         $display("ERROR: no operations found in the test data file");
         $display("Finished with errors");
         $fatal(1);
      end
      else
      begin
         limitCycles = numOps * 8;
         repeat (5) @(posedge clk);
         @(negedge clk);
         rst = 1'b0;
         for (int i = 0; i < numOps; i++)
            runOp(i);
         checkBarBurst();
         wrapRaisesIrq();
         $display("Finished with no errors");
         $finish;
      end
   end

   initial
   begin
      wait (limitCycles > 0);
      repeat (limitCycles) @(posedge clk);
      $display("TIMEOUT: run still busy after %0d cycles", limitCycles);
      $display("Finished with errors");
      $fatal(1);
   end

endmodule

// ==== verification/lpRegs_testdata.txt ====
// op (1 write, 2 event, 3 check) offset lanes (b0 lo, b1 hi) data eventMask regOut irq
// mask b0 dmaByte b1 formFeed b2 cmdGo b3 setUndc b4 setMpe b5 setDhld b6 clrDhld
// b7 irqAck b8 devReset, b9 online b10 vfuRdy b11 lpe are levels held until the next event
// reset state, printer comes up, ack the level change
3 0 0 000000000 000 0000 0
2 0 0 000000000 600 1800 0
2 0 0 000000000 680 1800 0
// write and readback, INIT, BAR and BAR high bits
1 0 1 00000004E 000 184E 0
1 0 2 000000100 000 1880 0
1 0 1 000000006 000 1886 0
1 1 1 0000000A5 000 00A5 0
1 1 2 000003C00 000 3CA5 0
1 0 1 000000026 000 18A6 0
// byte counter wrap to DONE, IE clear
1 2 3 000000FFE 000 0FFE 0
2 2 0 000000000 601 0FFF 0
2 0 0 000000000 601 18A6 0
2 0 0 000000000 680 18A6 0
// page counter to PCZ with IE set
1 3 1 000000002 000 0002 0
1 0 1 000000066 000 18E6 0
2 3 0 000000000 602 0001 0
2 0 0 000000000 602 58E6 1
2 0 0 000000000 680 58E6 0
1 3 1 000000005 000 0005 0
1 2 1 000000010 000 0010 0
3 0 0 000000000 000 1866 0
// ERR from online drop, lpe rise and setMpe, cleared by ECLR only
2 0 0 000000000 400 9066 1
2 0 0 000000000 600 9866 1
2 0 0 000000000 680 9866 0
1 0 2 000000000 000 9866 0
1 0 2 000000200 000 1866 0
2 0 0 000000000 E00 9866 1
2 0 0 000000000 E80 9866 0
1 0 2 000000200 000 1866 0
2 0 0 000000000 E10 9866 1
2 0 0 000000000 E80 9866 0
1 0 2 000000200 000 1866 0
// DHLD and UNDC
2 0 0 000000000 E20 1C66 0
2 0 0 000000000 E40 1866 0
1 0 2 000000400 000 1C66 0
2 0 0 000000000 E40 1866 0
2 0 0 000000000 E08 3866 1
2 0 0 000000000 E80 3866 0
2 0 0 000000000 E04 1866 0
// vfuRdy drop is an error, vfuRdy rise only interrupts
2 0 0 000000000 A00 8866 1
2 0 0 000000000 A80 8866 0
1 0 2 000000200 000 0866 0
2 0 0 000000000 E00 1866 1
2 0 0 000000000 E80 1866 0
// IE clear holds irq low, pending shows once IE returns
1 0 1 000000026 000 1826 0
2 0 0 000000000 E08 3826 0
1 0 1 000000066 000 3866 1
2 0 0 000000000 E20 3C66 1
// devReset initializes
2 0 0 000000000 F00 3880 0
3 1 0 000000000 000 0000 0
3 2 0 000000000 000 0000 0
3 3 0 000000000 000 0000 0

// ==== filelist.f ====
+incdir+hw
hw/lpPkg.sv
hw/lpRegDecode.sv
hw/lpCsra.sv
hw/lpBar.sv
hw/lpCounters.sv
hw/lpIntr.sv
hw/lpRegs.sv
verification/lpRegsTb.sv

// ==== Makefile ====
# Verilator build and run for the LP20 register slice testbench

VERILATOR ?= verilator
SEED      ?= 91aa82cb
TOP       ?= lpRegsTb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' filelist.f)
HEADERS  = hw/lp20_defs.svh
DATA     = verification/lpRegs_testdata.txt

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) filelist.f
	$(VERILATOR) --binary --assert -j 0 --Mdir $(OBJ_DIR) --top-module $(TOP) \
		-GrngSeed="32'h$(SEED)" -f filelist.f

run: $(BIN) $(DATA)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "Finished with no errors" $(LOG) || (echo "Simulation incomplete"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
